// ==== sources.f ====
+incdir+.
mipsIsaPkg.sv
mipsExecPkg.sv
decodeBus.sv
execBus.sv
instrDecoder.sv
aluExecute.sv
hiLoWriteback.sv
mipsExecUnit.sv
tb_mipsExecUnit.sv

// ==== Bender.yml ====
package:
  name: mips_exec_unit

export_include_dirs:
  - .

sources:
  - mipsIsaPkg.sv
  - mipsExecPkg.sv
  - decodeBus.sv
  - execBus.sv
  - instrDecoder.sv
  - aluExecute.sv
  - hiLoWriteback.sv
  - mipsExecUnit.sv
  - target: simulation
    files:
      - tb_mipsExecUnit.sv

// ==== tb_mipsExecUnit.sv ====
`include "mips_macros.svh"
`default_nettype none

module tb_mipsExecUnit;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int cycleNs = 4;
   localparam int resetCycles = 10;
   localparam int directedCount = 20;
   localparam int randomCount = 400;
   localparam int budgetNs = (resetCycles + 20 * (directedCount + randomCount)) * cycleNs;

   typedef struct packed {
      logic write;
      logic [`MIPS_REG_W-1:0] dest;
      logic [`MIPS_DATA_W-1:0] data;
      mipsExecPkg::excCode exc;
   } wbRecord;

   logic clk;
   logic rst;
   logic [`MIPS_INSTR_W-1:0] instr;
   logic [`MIPS_DATA_W-1:0] rsVal;
   logic [`MIPS_DATA_W-1:0] rtVal;
   logic inValid;
   logic inReady;
   logic wbWrite;
   logic [`MIPS_REG_W-1:0] wbReg;
   logic [`MIPS_DATA_W-1:0] wbData;
   mipsExecPkg::excCode wbExc;
   logic outValid;
   logic outReady;

   logic backPressure;
   int drainCycles;
   logic [`MIPS_DATA_W-1:0] refHi;
   logic [`MIPS_DATA_W-1:0] refLo;
   wbRecord expQ[$];

   logic [5:0] rFuncts [0:21] = '{
      mipsIsaPkg::fnAdd, mipsIsaPkg::fnAddu, mipsIsaPkg::fnSub, mipsIsaPkg::fnSubu,
      mipsIsaPkg::fnAnd, mipsIsaPkg::fnOr, mipsIsaPkg::fnXor, mipsIsaPkg::fnNor,
      mipsIsaPkg::fnSlt, mipsIsaPkg::fnSltu, mipsIsaPkg::fnSll, mipsIsaPkg::fnSrl,
      mipsIsaPkg::fnSra, mipsIsaPkg::fnSllv, mipsIsaPkg::fnSrlv, mipsIsaPkg::fnSrav,
      mipsIsaPkg::fnMult, mipsIsaPkg::fnMultu, mipsIsaPkg::fnMfhi, mipsIsaPkg::fnMflo,
      mipsIsaPkg::fnMthi, mipsIsaPkg::fnMtlo};
   logic [5:0] iOpcodes [0:7] = '{
      mipsIsaPkg::opAddi, mipsIsaPkg::opAddiu, mipsIsaPkg::opSlti, mipsIsaPkg::opSltiu,
      mipsIsaPkg::opAndi, mipsIsaPkg::opOri, mipsIsaPkg::opXori, mipsIsaPkg::opLui};

   mipsExecUnit u_mipsExecUnit (
      .clk(clk),
      .rst(rst),
      .instr(instr),
      .rsVal(rsVal),
      .rtVal(rtVal),
      .inValid(inValid),
      .inReady(inReady),
      .wbWrite(wbWrite),
      .wbReg(wbReg),
      .wbData(wbData),
      .wbExc(wbExc),
      .outValid(outValid),
      .outReady(outReady)
   );

   initial begin
      clk = 1'b0;
      forever #(cycleNs / 2) clk = ~clk;
   end

   task automatic abortRun();
      $display("Simulation FAILED");
      $fatal(1, "run stopped at %0t ns", $time);
   endtask

   ////////////////////
   // compare tasks
   task automatic compareData(input string name, input logic [`MIPS_DATA_W-1:0] expVal,
                              input logic [`MIPS_DATA_W-1:0] actVal);
      if (actVal !== expVal) begin
         $display("error at %0t ns: %s expected %h actual %h", $time, name, expVal, actVal);
         abortRun();
      end
   endtask

   task automatic compareReg(input string name, input logic [`MIPS_REG_W-1:0] expVal,
                             input logic [`MIPS_REG_W-1:0] actVal);
      if (actVal !== expVal) begin
         $display("error at %0t ns: %s expected %0d actual %0d", $time, name, expVal, actVal);
         abortRun();
      end
   endtask

   task automatic compareExc(input string name, input mipsExecPkg::excCode expVal,
                             input mipsExecPkg::excCode actVal);
      if (actVal !== expVal) begin
         $display("error at %0t ns: %s expected %s actual %s", $time, name, expVal.name(),
                  actVal.name());
         abortRun();
      end
   endtask

   task automatic compareBit(input string name, input logic expVal, input logic actVal);
      if (actVal !== expVal) begin
         $display("error at %0t ns: %s expected %b actual %b", $time, name, expVal, actVal);
         abortRun();
      end
   endtask

   ////////////////////
   // reference model with its own hi/lo kept in issue order
   function automatic wbRecord referenceResult(input mipsIsaPkg::instrWord w,
                                               input logic [`MIPS_DATA_W-1:0] rs,
                                               input logic [`MIPS_DATA_W-1:0] rt);
      wbRecord r;
      logic [`MIPS_DATA_W-1:0] sext;
      logic [`MIPS_DATA_W-1:0] zext;
      logic [2*`MIPS_DATA_W-1:0] prod;
      r.write = 1'b1;
      r.dest = w.rType.rd;
      r.data = '0;
      r.exc = mipsExecPkg::excNone;
      sext = {{16{w.iType.imm[15]}}, w.iType.imm};
      zext = {16'h0000, w.iType.imm};
      if (w.rType.opcode == mipsIsaPkg::opSpecial) begin
         case (w.rType.funct)
            mipsIsaPkg::fnAdd, mipsIsaPkg::fnAddu: r.data = rs + rt;
            mipsIsaPkg::fnSub, mipsIsaPkg::fnSubu: r.data = rs - rt;
            mipsIsaPkg::fnAnd: r.data = rs & rt;
            mipsIsaPkg::fnOr: r.data = rs | rt;
            mipsIsaPkg::fnXor: r.data = rs ^ rt;
            mipsIsaPkg::fnNor: r.data = ~(rs | rt);
            mipsIsaPkg::fnSlt: r.data = ($signed(rs) < $signed(rt)) ? 1 : 0;
            mipsIsaPkg::fnSltu: r.data = (rs < rt) ? 1 : 0;
            mipsIsaPkg::fnSll: r.data = rt << w.rType.shamt;
            mipsIsaPkg::fnSrl: r.data = rt >> w.rType.shamt;
            mipsIsaPkg::fnSra: r.data = $signed(rt) >>> w.rType.shamt;
            mipsIsaPkg::fnSllv: r.data = rt << rs[4:0];
            mipsIsaPkg::fnSrlv: r.data = rt >> rs[4:0];
            mipsIsaPkg::fnSrav: r.data = $signed(rt) >>> rs[4:0];
            mipsIsaPkg::fnMult, mipsIsaPkg::fnMultu: begin
               if (w.rType.funct == mipsIsaPkg::fnMult) begin
                  prod = longint'($signed(rs)) * longint'($signed(rt));
               end else begin
                  prod = {32'h0, rs} * {32'h0, rt};
               end
               refHi = prod[63:32];
               refLo = prod[31:0];
               r.write = 1'b0;
            end
            mipsIsaPkg::fnMfhi: r.data = refHi;
            mipsIsaPkg::fnMflo: r.data = refLo;
            mipsIsaPkg::fnMthi, mipsIsaPkg::fnMtlo: begin
               if (w.rType.funct == mipsIsaPkg::fnMthi) refHi = rs;
               else refLo = rs;
               r.write = 1'b0;
            end
            mipsIsaPkg::fnSyscall: r.exc = mipsExecPkg::excSyscall;
            mipsIsaPkg::fnBreak: r.exc = mipsExecPkg::excBreak;
            default: r.exc = mipsExecPkg::excInvalid;
         endcase
      end else begin
         r.dest = w.iType.rt;
         case (w.iType.opcode)
            mipsIsaPkg::opAddi, mipsIsaPkg::opAddiu: r.data = rs + sext;
            mipsIsaPkg::opSlti: r.data = ($signed(rs) < $signed(sext)) ? 1 : 0;
            mipsIsaPkg::opSltiu: r.data = (rs < sext) ? 1 : 0;
            mipsIsaPkg::opAndi: r.data = rs & zext;
            mipsIsaPkg::opOri: r.data = rs | zext;
            mipsIsaPkg::opXori: r.data = rs ^ zext;
            mipsIsaPkg::opLui: r.data = {w.iType.imm, 16'h0000};
            default: r.exc = mipsExecPkg::excInvalid;
         endcase
      end
      if (w == '0 || r.exc != mipsExecPkg::excNone) begin
         r.write = 1'b0;
      end
      return r;
   endfunction

   function automatic logic [`MIPS_INSTR_W-1:0] rWord(input logic [5:0] funct,
                                                      input logic [`MIPS_REG_W-1:0] rd);
      mipsIsaPkg::instrWord w;
      w = '0;
      w.rType.funct = funct;
      w.rType.rd = rd;
      return w;
   endfunction

   function automatic logic [`MIPS_INSTR_W-1:0] iWord(input logic [5:0] opcode,
                                                      input logic [`MIPS_REG_W-1:0] rt,
                                                      input logic [15:0] imm);
      mipsIsaPkg::instrWord w;
      w = '0;
      w.iType.opcode = opcode;
      w.iType.rt = rt;
      w.iType.imm = imm;
      return w;
   endfunction

   // called on a falling edge and returns on the falling edge after the transfer
   task automatic issue(input logic [`MIPS_INSTR_W-1:0] word, input logic [`MIPS_DATA_W-1:0] rs,
                        input logic [`MIPS_DATA_W-1:0] rt);
      logic taken;
      instr = word;
      rsVal = rs;
      rtVal = rt;
      inValid = 1'b1;
      taken = 1'b0;
      while (!taken) begin
         #1;
         taken = inReady;
         if (taken) expQ.push_back(referenceResult(word, rs, rt));
         @(negedge clk);
      end
      inValid = 1'b0;
   endtask

   task automatic issueRandom();
      mipsIsaPkg::instrWord w;
      int pick;
      pick = $urandom % 8;
      w = $urandom;
      if (pick < 4) begin
         w.rType.opcode = mipsIsaPkg::opSpecial;
         w.rType.funct = rFuncts[$urandom % 22];
      end else if (pick < 7) begin
         w.iType.opcode = iOpcodes[$urandom % 8];
      end
      // remaining picks keep the raw random word
      issue(w, $urandom, $urandom);
      if ($urandom % 4 == 0) @(negedge clk);
   endtask

   task automatic driveReady();
      forever begin
         @(negedge clk);
         outReady = backPressure ? ($urandom % 2) : 1'b1;
      end
   endtask

   ////////////////////
   // output monitor
   initial begin
      wbRecord got;
      wbRecord want;
      wbRecord held;
      logic holding;
      holding = 1'b0;
      @(negedge rst);
      forever begin
         @(negedge clk);
         #1;
         got.write = wbWrite;
         got.dest = wbReg;
         got.data = wbData;
         got.exc = wbExc;
         if (holding) begin
            compareBit("outValid held", 1'b1, outValid);
            compareBit("wbWrite held", held.write, got.write);
            compareReg("wbReg held", held.dest, got.dest);
            compareData("wbData held", held.data, got.data);
            compareExc("wbExc held", held.exc, got.exc);
         end
         // input stalls only while a beat waits at the output
         if (outValid && !outReady) begin
            compareBit("inReady", 1'b0, inReady);
         end else begin
            compareBit("inReady", 1'b1, inReady);
         end
         holding = outValid && !outReady;
         held = got;
         if (outValid && outReady) begin
            if (expQ.size() == 0) begin
               $display("output beat at %0t ns with no instruction pending", $time);
               abortRun();
            end else begin
               want = expQ.pop_front();
               compareBit("wbWrite", want.write, got.write);
               compareExc("wbExc", want.exc, got.exc);
               if (want.write) begin
                  compareReg("wbReg", want.dest, got.dest);
                  compareData("wbData", want.data, got.data);
               end
            end
         end
      end
   end

   initial begin
      #(budgetNs);
      $display("output stalled, no progress within %0d ns", budgetNs);
      abortRun();
   end

   ////////////////////
   // stimulus
   initial begin
      instr = '0;
      rsVal = '0;
      rtVal = '0;
      inValid = 1'b0;
      outReady = 1'b1;
      rst = 1'b1;
      backPressure = 1'b0;
      refHi = '0;
      refLo = '0;
      void'($urandom(32'he17e_7ece));
      fork
         driveReady();
      join_none
      repeat (resetCycles) @(negedge clk);
      rst = 1'b0;
      compareBit("outValid", 1'b0, outValid);
      // hi/lo start at zero
      issue(rWord(mipsIsaPkg::fnMfhi, 5'd3), 32'h1111_1111, 32'h2222_2222);
      issue(rWord(mipsIsaPkg::fnMflo, 5'd4), 32'h0, 32'h0);
      issue('0, 32'hffff_ffff, 32'hffff_ffff);
      issue(rWord(mipsIsaPkg::fnMult, 5'd0), 32'hffff_fff9, 32'd123456);
      issue(rWord(mipsIsaPkg::fnMfhi, 5'd5), 32'h0, 32'h0);
      issue(rWord(mipsIsaPkg::fnMflo, 5'd6), 32'h0, 32'h0);
      issue(rWord(mipsIsaPkg::fnMultu, 5'd0), 32'hffff_ffff, 32'h1234_5678);
      issue(rWord(mipsIsaPkg::fnMfhi, 5'd7), 32'h0, 32'h0);
      issue(rWord(mipsIsaPkg::fnMflo, 5'd8), 32'h0, 32'h0);
      issue(rWord(mipsIsaPkg::fnMthi, 5'd0), 32'hdead_beef, 32'h5555_5555);
      issue(rWord(mipsIsaPkg::fnMtlo, 5'd0), 32'h0123_4567, 32'haaaa_aaaa);
      issue(rWord(mipsIsaPkg::fnMfhi, 5'd9), 32'h0, 32'h0);
      issue(rWord(mipsIsaPkg::fnMflo, 5'd10), 32'h0, 32'h0);
      // traps and words outside the slice
      issue(rWord(mipsIsaPkg::fnSyscall, 5'd1), 32'h1, 32'h2);
      issue(rWord(mipsIsaPkg::fnBreak, 5'd2), 32'h3, 32'h4);
      issue(rWord(mipsIsaPkg::fnDiv, 5'd3), 32'h64, 32'h7);
      issue(rWord(mipsIsaPkg::fnDivu, 5'd4), 32'h64, 32'h7);
      issue(iWord(6'b000010, 5'd5, 16'h1234), 32'h0, 32'h0);
      issue(iWord(mipsIsaPkg::opRegimm, mipsIsaPkg::riBgez, 16'h0010), 32'h0, 32'h0);
      issue(iWord(6'b100011, 5'd6, 16'h0004), 32'h100, 32'h0);
      backPressure = 1'b1;
      repeat (randomCount) issueRandom();
      backPressure = 1'b0;
      drainCycles = 0;
      while (expQ.size() != 0 && drainCycles < 50) begin
         @(negedge clk);
         drainCycles++;
      end
      if (expQ.size() != 0) begin
         $display("%0d expected output beats never appeared", expQ.size());
         abortRun();
      end else begin
         $display("Simulation PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== mipsExecUnit.sv ====
`include "mips_macros.svh"
`default_nettype none

module mipsExecUnit (
   input  logic clk,
   input  logic rst,
   input  logic [`MIPS_INSTR_W-1:0] instr,
   input  logic [`MIPS_DATA_W-1:0] rsVal,
   input  logic [`MIPS_DATA_W-1:0] rtVal,
   input  logic inValid,
   output logic inReady,
   output logic wbWrite,
   output logic [`MIPS_REG_W-1:0] wbReg,
   output logic [`MIPS_DATA_W-1:0] wbData,
   output mipsExecPkg::excCode wbExc,
   output logic outValid,
   input  logic outReady
);

   logic advance;

   decodeBus decBus ();
   execBus exBus ();

   // whole pipe moves together and freezes while the output is held
   assign advance = !outValid || outReady;
   assign inReady = advance;

   instrDecoder u_instrDecoder (
      .clk(clk),
      .rst(rst),
      .advance(advance),
      .instr(instr),
      .rsVal(rsVal),
      .rtVal(rtVal),
      .inValid(inValid),
      .dec(decBus.producer)
   );

   aluExecute u_aluExecute (
      .clk(clk),
      .rst(rst),
      .advance(advance),
      .dec(decBus.consumer),
      .ex(exBus.producer)
   );

   hiLoWriteback u_hiLoWriteback (
      .clk(clk),
      .rst(rst),
      .advance(advance),
      .ex(exBus.consumer),
      .wbWrite(wbWrite),
      .wbReg(wbReg),
      .wbData(wbData),
      .wbExc(wbExc),
      .outValid(outValid)
   );

endmodule

`default_nettype wire

// ==== hiLoWriteback.sv ====
`include "mips_macros.svh"
`default_nettype none

module hiLoWriteback (
   input  logic clk,
   input  logic rst,
   input  logic advance,
   execBus.consumer ex,
   output logic wbWrite,
   output logic [`MIPS_REG_W-1:0] wbReg,
   output logic [`MIPS_DATA_W-1:0] wbData,
   output mipsExecPkg::excCode wbExc,
   output logic outValid
);

   logic [`MIPS_DATA_W-1:0] hi;
   logic [`MIPS_DATA_W-1:0] lo;
   logic [`MIPS_DATA_W-1:0] data;

   ////////////////////
   // hi/lo updated in program order
   always_ff @(posedge clk) begin
      if (rst) begin
         hi <= '0;
         lo <= '0;
      end else if (advance && ex.valid) begin
         if (ex.mult) begin
            {hi, lo} <= ex.product;
         end else if (ex.hiLoWrite) begin
            if (ex.hl) begin
               hi <= ex.result;
            end else begin
               lo <= ex.result;
            end
         end
      end
   end

   always_comb begin
      case (ex.sel)
         mipsExecPkg::selReadHi: data = hi;
         mipsExecPkg::selReadLo: data = lo;
         default: data = ex.result;
      endcase
   end

   // output beat
   always_ff @(posedge clk) begin
      if (rst) begin
         outValid <= 1'b0;
      end else if (advance) begin
         outValid <= ex.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         wbWrite <= ex.regWrite;
         wbReg <= ex.dest;
         wbData <= data;
         wbExc <= ex.exc;
      end
   end

endmodule

`default_nettype wire

// ==== aluExecute.sv ====
`include "mips_macros.svh"
`default_nettype none

module aluExecute (
   input  logic clk,
   input  logic rst,
   input  logic advance,
   decodeBus.consumer dec,
   execBus.producer ex
);

   logic [`MIPS_DATA_W-1:0] result;
   logic [2*`MIPS_DATA_W-1:0] product;
   logic [2*`MIPS_DATA_W-1:0] aWide;
   logic [2*`MIPS_DATA_W-1:0] bWide;

   always_comb begin
      case (dec.op)
         mipsExecPkg::aluAdd: result = dec.a + dec.b;
         mipsExecPkg::aluSub: result = dec.a - dec.b;
         mipsExecPkg::aluSlt: result = {{(`MIPS_DATA_W-1){1'b0}}, $signed(dec.a) < $signed(dec.b)};
         mipsExecPkg::aluSltu: result = {{(`MIPS_DATA_W-1){1'b0}}, dec.a < dec.b};
         mipsExecPkg::aluAnd: result = dec.a & dec.b;
         mipsExecPkg::aluOr: result = dec.a | dec.b;
         mipsExecPkg::aluXor: result = dec.a ^ dec.b;
         mipsExecPkg::aluNor: result = ~(dec.a | dec.b);
         // shifts act on rt
         mipsExecPkg::aluSll: result = dec.b << dec.shamt;
         mipsExecPkg::aluSrl: result = dec.b >> dec.shamt;
         mipsExecPkg::aluSra: result = $signed(dec.b) >>> dec.shamt;
         mipsExecPkg::aluLui: result = {dec.b[15:0], 16'h0000};
         default: result = '0;
      endcase
   end

   ////////////////////
   // multiplier on operands widened to 64 bits
   assign aWide = {{`MIPS_DATA_W{dec.multSigned & dec.a[`MIPS_DATA_W-1]}}, dec.a};
   assign bWide = {{`MIPS_DATA_W{dec.multSigned & dec.b[`MIPS_DATA_W-1]}}, dec.b};
   assign product = dec.mult ? aWide * bWide : '0;

   always_ff @(posedge clk) begin
      if (rst) begin
         ex.valid <= 1'b0;
      end else if (advance) begin
         ex.valid <= dec.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         ex.result <= result;
         ex.product <= product;
         ex.dest <= dec.dest;
         ex.regWrite <= dec.regWrite;
         ex.mult <= dec.mult;
         ex.hiLoWrite <= dec.hiLoWrite;
         ex.hl <= dec.hl;
         ex.sel <= dec.sel;
         ex.exc <= dec.exc;
      end
   end

endmodule

`default_nettype wire

// ==== instrDecoder.sv ====
`include "mips_macros.svh"
`default_nettype none

module instrDecoder (
   input  logic clk,
   input  logic rst,
   input  logic advance,
   input  mipsIsaPkg::instrWord instr,
   input  logic [`MIPS_DATA_W-1:0] rsVal,
   input  logic [`MIPS_DATA_W-1:0] rtVal,
   input  logic inValid,
   decodeBus.producer dec
);

   // operand b sources
   localparam logic [1:0] bRt   = 2'd0;
   localparam logic [1:0] bSext = 2'd1;
   localparam logic [1:0] bZext = 2'd2;
   localparam logic [1:0] bZero = 2'd3;

   mipsExecPkg::aluOp op;
   mipsExecPkg::hiLoSel sel;
   mipsExecPkg::excCode exc;
   logic [1:0] bSrc;
   logic shiftVar;
   logic destRt;
   logic regWrite;
   logic mult;
   logic multSigned;
   logic hiLoWrite;
   logic hl;
   logic [`MIPS_DATA_W-1:0] bVal;
   logic [`MIPS_SHAMT_W-1:0] shamt;
   logic [`MIPS_REG_W-1:0] dest;

   ////////////////////
   // main decoder
   always_comb begin
      op = mipsExecPkg::aluAdd;
      sel = mipsExecPkg::selAlu;
      exc = mipsExecPkg::excNone;
      bSrc = bRt;
      shiftVar = 1'b0;
      destRt = 1'b0;
      regWrite = 1'b1;
      mult = 1'b0;
      multSigned = 1'b0;
      hiLoWrite = 1'b0;
      hl = 1'b0;
      case (instr.rType.opcode)
         mipsIsaPkg::opSpecial: begin
            case (instr.rType.funct)
               mipsIsaPkg::fnAdd, mipsIsaPkg::fnAddu: op = mipsExecPkg::aluAdd;
               mipsIsaPkg::fnSub, mipsIsaPkg::fnSubu: op = mipsExecPkg::aluSub;
               mipsIsaPkg::fnSlt: op = mipsExecPkg::aluSlt;
               mipsIsaPkg::fnSltu: op = mipsExecPkg::aluSltu;
               mipsIsaPkg::fnAnd: op = mipsExecPkg::aluAnd;
               mipsIsaPkg::fnOr: op = mipsExecPkg::aluOr;
               mipsIsaPkg::fnXor: op = mipsExecPkg::aluXor;
               mipsIsaPkg::fnNor: op = mipsExecPkg::aluNor;
               mipsIsaPkg::fnSll: op = mipsExecPkg::aluSll;
               mipsIsaPkg::fnSrl: op = mipsExecPkg::aluSrl;
               mipsIsaPkg::fnSra: op = mipsExecPkg::aluSra;
               mipsIsaPkg::fnSllv: begin
                  op = mipsExecPkg::aluSll;
                  shiftVar = 1'b1;
               end
               mipsIsaPkg::fnSrlv: begin
                  op = mipsExecPkg::aluSrl;
                  shiftVar = 1'b1;
               end
               mipsIsaPkg::fnSrav: begin
                  op = mipsExecPkg::aluSra;
                  shiftVar = 1'b1;
               end
               mipsIsaPkg::fnMult, mipsIsaPkg::fnMultu: begin
                  mult = 1'b1;
                  multSigned = (instr.rType.funct == mipsIsaPkg::fnMult);
                  regWrite = 1'b0;
               end
               mipsIsaPkg::fnMfhi: sel = mipsExecPkg::selReadHi;
               mipsIsaPkg::fnMflo: sel = mipsExecPkg::selReadLo;
               mipsIsaPkg::fnMthi, mipsIsaPkg::fnMtlo: begin
                  // rs passes through the adder
                  bSrc = bZero;
                  hiLoWrite = 1'b1;
                  hl = (instr.rType.funct == mipsIsaPkg::fnMthi);
                  regWrite = 1'b0;
               end
               mipsIsaPkg::fnSyscall: exc = mipsExecPkg::excSyscall;
               mipsIsaPkg::fnBreak: exc = mipsExecPkg::excBreak;
               default: exc = mipsExecPkg::excInvalid;
            endcase
         end
         mipsIsaPkg::opAddi, mipsIsaPkg::opAddiu: begin
            bSrc = bSext;
            destRt = 1'b1;
         end
         mipsIsaPkg::opSlti, mipsIsaPkg::opSltiu: begin
            op = (instr.iType.opcode == mipsIsaPkg::opSlti) ? mipsExecPkg::aluSlt
                                                             : mipsExecPkg::aluSltu;
            bSrc = bSext;
            destRt = 1'b1;
         end
         mipsIsaPkg::opAndi, mipsIsaPkg::opOri, mipsIsaPkg::opXori, mipsIsaPkg::opLui: begin
            case (instr.iType.opcode)
               mipsIsaPkg::opAndi: op = mipsExecPkg::aluAnd;
               mipsIsaPkg::opOri: op = mipsExecPkg::aluOr;
               mipsIsaPkg::opXori: op = mipsExecPkg::aluXor;
               default: op = mipsExecPkg::aluLui;
            endcase
            bSrc = bZext;
            destRt = 1'b1;
         end
         // branches, memory and cp0 are not part of this slice
         default: exc = mipsExecPkg::excInvalid;
      endcase
      // nop and trapping words never write
      if (instr == '0 || exc != mipsExecPkg::excNone) begin
         regWrite = 1'b0;
      end
   end

   always_comb begin
      case (bSrc)
         bSext: bVal = {{(`MIPS_DATA_W-16){instr.iType.imm[15]}}, instr.iType.imm};
         bZext: bVal = {{(`MIPS_DATA_W-16){1'b0}}, instr.iType.imm};
         bZero: bVal = '0;
         default: bVal = rtVal;
      endcase
   end

   assign shamt = shiftVar ? rsVal[`MIPS_SHAMT_W-1:0] : instr.rType.shamt;
   assign dest = destRt ? instr.iType.rt : instr.rType.rd;

   ////////////////////
   // decode stage register
   always_ff @(posedge clk) begin
      if (rst) begin
         dec.valid <= 1'b0;
      end else if (advance) begin
         dec.valid <= inValid;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         dec.op <= op;
         dec.a <= rsVal;
         dec.b <= bVal;
         dec.shamt <= shamt;
         dec.dest <= dest;
         dec.regWrite <= regWrite;
         dec.mult <= mult;
         dec.multSigned <= multSigned;
         dec.hiLoWrite <= hiLoWrite;
         dec.hl <= hl;
         dec.sel <= sel;
         dec.exc <= exc;
      end
   end

endmodule

`default_nettype wire

// ==== execBus.sv ====
`include "mips_macros.svh"
`default_nettype none

interface execBus;
   logic valid;
   logic [`MIPS_DATA_W-1:0] result;
   logic [2*`MIPS_DATA_W-1:0] product;
   logic [`MIPS_REG_W-1:0] dest;
   logic regWrite;
   logic mult;
   logic hiLoWrite;
   logic hl;
   mipsExecPkg::hiLoSel sel;
   mipsExecPkg::excCode exc;

   modport producer (output valid, result, product, dest, regWrite, mult, hiLoWrite, hl,
                     sel, exc);
   modport consumer (input valid, result, product, dest, regWrite, mult, hiLoWrite, hl,
                     sel, exc);
endinterface

`default_nettype wire

// ==== decodeBus.sv ====
`include "mips_macros.svh"
`default_nettype none

interface decodeBus;
   logic valid;
   mipsExecPkg::aluOp op;
   logic [`MIPS_DATA_W-1:0] a;
   logic [`MIPS_DATA_W-1:0] b;
   logic [`MIPS_SHAMT_W-1:0] shamt;
   logic [`MIPS_REG_W-1:0] dest;
   logic regWrite;
   logic mult;
   logic multSigned;
   logic hiLoWrite;
   logic hl;
   mipsExecPkg::hiLoSel sel;
   mipsExecPkg::excCode exc;

   modport producer (output valid, op, a, b, shamt, dest, regWrite, mult, multSigned,
                     hiLoWrite, hl, sel, exc);
   modport consumer (input valid, op, a, b, shamt, dest, regWrite, mult, multSigned,
                     hiLoWrite, hl, sel, exc);
endinterface

`default_nettype wire

// ==== mipsExecPkg.sv ====
`default_nettype none

package mipsExecPkg;

   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluSlt,
      aluSltu,
      aluAnd,
      aluOr,
      aluXor,
      aluNor,
      aluSll,
      aluSrl,
      aluSra,
      aluLui
   } aluOp;

   typedef enum logic [1:0] {
      excNone,
      excSyscall,
      excBreak,
      excInvalid
   } excCode;

   // source of the writeback data
   typedef enum logic [1:0] {
      selAlu,
      selReadHi,
      selReadLo
   } hiLoSel;

endpackage

`default_nettype wire

// ==== mipsIsaPkg.sv ====
`include "mips_macros.svh"
`default_nettype none

package mipsIsaPkg;

   ////////////////////
   // opcodes
   localparam logic [5:0] opSpecial = 6'b000000;
   localparam logic [5:0] opRegimm  = 6'b000001;
   localparam logic [5:0] opAddi    = 6'b001000;
   localparam logic [5:0] opAddiu   = 6'b001001;
   localparam logic [5:0] opSlti    = 6'b001010;
   localparam logic [5:0] opSltiu   = 6'b001011;
   localparam logic [5:0] opAndi    = 6'b001100;
   localparam logic [5:0] opOri     = 6'b001101;
   localparam logic [5:0] opXori    = 6'b001110;
   localparam logic [5:0] opLui     = 6'b001111;

   ////////////////////
   // funct field of SPECIAL
   localparam logic [5:0] fnSll     = 6'b000000;
   localparam logic [5:0] fnSrl     = 6'b000010;
   localparam logic [5:0] fnSra     = 6'b000011;
   localparam logic [5:0] fnSllv    = 6'b000100;
   localparam logic [5:0] fnSrlv    = 6'b000110;
   localparam logic [5:0] fnSrav    = 6'b000111;
   localparam logic [5:0] fnSyscall = 6'b001100;
   localparam logic [5:0] fnBreak   = 6'b001101;
   localparam logic [5:0] fnMfhi    = 6'b010000;
   localparam logic [5:0] fnMthi    = 6'b010001;
   localparam logic [5:0] fnMflo    = 6'b010010;
   localparam logic [5:0] fnMtlo    = 6'b010011;
   localparam logic [5:0] fnMult    = 6'b011000;
   localparam logic [5:0] fnMultu   = 6'b011001;
   localparam logic [5:0] fnDiv     = 6'b011010;
   localparam logic [5:0] fnDivu    = 6'b011011;
   localparam logic [5:0] fnAdd     = 6'b100000;
   localparam logic [5:0] fnAddu    = 6'b100001;
   localparam logic [5:0] fnSub     = 6'b100010;
   localparam logic [5:0] fnSubu    = 6'b100011;
   localparam logic [5:0] fnAnd     = 6'b100100;
   localparam logic [5:0] fnOr      = 6'b100101;
   localparam logic [5:0] fnXor     = 6'b100110;
   localparam logic [5:0] fnNor     = 6'b100111;
   localparam logic [5:0] fnSlt     = 6'b101010;
   localparam logic [5:0] fnSltu    = 6'b101011;

   // rt field of REGIMM
   localparam logic [4:0] riBltz = 5'b00000;
   localparam logic [4:0] riBgez = 5'b00001;

   typedef struct packed {
      logic [5:0] opcode;
      logic [`MIPS_REG_W-1:0] rs;
      logic [`MIPS_REG_W-1:0] rt;
      logic [`MIPS_REG_W-1:0] rd;
      logic [`MIPS_SHAMT_W-1:0] shamt;
      logic [5:0] funct;
   } rTypeFields;

   typedef struct packed {
      logic [5:0] opcode;
      logic [`MIPS_REG_W-1:0] rs;
      logic [`MIPS_REG_W-1:0] rt;
      logic [15:0] imm;
   } iTypeFields;

   // same word read as R-type or I-type
   typedef union packed {
      rTypeFields rType;
      iTypeFields iType;
   } instrWord;

endpackage

`default_nettype wire

// ==== mips_macros.svh ====
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// widths fixed by the ISA
`define MIPS_DATA_W 32
`define MIPS_INSTR_W 32

// register file index
`define MIPS_REG_W 5

// shift amount field
`define MIPS_SHAMT_W 5

`endif
